//--- flist.f
source/resizer_pkg.sv
source/stream_if.sv
source/resizer_settings.sv
source/packet_resizer.sv
source/seq_stamper.sv
source/resizer_top.sv
testbench/tb_resizer.sv

//--- Makefile
# Verilator build and run for the packet resizer testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_resizer
FILELIST = flist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/tb_resizer.sv
// Random-stimulus testbench for resizer_top, checks every cycle against a reference model
`timescale 1ns/1ps

module tb_resizer;

   localparam int P_REG    = 200;    // Register write phase, cycles
   localparam int P_RESIZE = 150;    // Per packet-size round
   localparam int N_RESIZE = 8;
   localparam int P_BURST  = 600;
   localparam int P_SEQ    = 5000;   // Long burst at size 4
   localparam int P_STALL  = 800;
   localparam int TIMEOUT_CYCLES =
      (P_REG + N_RESIZE * P_RESIZE + P_BURST + P_SEQ + P_STALL) * 4;

   logic                                clk;
   logic                                reset;
   logic                                i_set_stb;
   logic [resizer_pkg::SET_ADDR_W-1:0] i_set_addr;
   logic [resizer_pkg::SET_DATA_W-1:0] i_set_data;
   resizer_pkg::data_t                  i_tdata;
   resizer_pkg::header_t                i_tuser;
   logic                                i_tlast;
   logic                                i_tvalid;
   logic                                i_tready;
   resizer_pkg::data_t                  o_tdata;
   resizer_pkg::header_t                o_tuser;
   logic                                o_tlast;
   logic                                o_tvalid;
   logic                                o_tready;

   // Reference model state
   resizer_pkg::size_t m_count;
   resizer_pkg::size_t m_size;
   resizer_pkg::sid_t  m_dest;
   resizer_pkg::seq_t  m_seq;
   logic               m_first;
   logic               seq_wrapped;

   // Traffic shape, percentages
   int valid_pct;
   int ready_pct;
   int eob_pct;
   int last_pct;
   int tsi_pct;

   logic                                pend_stb;
   logic [resizer_pkg::SET_ADDR_W-1:0] pend_addr;
   logic [resizer_pkg::SET_DATA_W-1:0] pend_data;
   logic                                close_req;       // Next free beat ends the burst
   logic                                close_pending;   // Burst end beat is on the bus

   logic [31:0] lcg_state = 32'd53;
   int          cycle_count = 0;

   resizer_top dut (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_tdata    (i_tdata),
      .i_tuser    (i_tuser),
      .i_tlast    (i_tlast),
      .i_tvalid   (i_tvalid),
      .i_tready   (i_tready),
      .o_tdata    (o_tdata),
      .o_tuser    (o_tuser),
      .o_tlast    (o_tlast),
      .o_tvalid   (o_tvalid),
      .o_tready   (o_tready)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
         $display("*** FAILED ***");
         $fatal(1, "Run aborted on timeout");
      end
   end

   function automatic logic [31:0] next_random();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   function automatic bit chance(int pct);
      return int'((next_random() >> 16) % 32'd100) < pct;   // Upper bits are better mixed
   endfunction

   function automatic resizer_pkg::header_t random_header();
      return {next_random(), next_random(), next_random(), next_random()};
   endfunction

   function automatic resizer_pkg::size_t random_size();
      return resizer_pkg::size_t'(4 * (1 + (next_random() >> 16) % 32'd16));   // 4 to 64
   endfunction

   task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
      if (expected !== actual) begin
         $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic set_traffic(int v, int r, int e, int l);
      valid_pct = v;
      ready_pct = r;
      eob_pct   = e;
      last_pct  = l;
   endtask

   // Check outputs mid-cycle, advance the model, then drive the next inputs
   task automatic run_cycle();
      resizer_pkg::header_t exp_user;
      resizer_pkg::header_t hdr;
      logic                 exp_eob;
      logic                 exp_last;
      logic                 xfer;
      @(negedge clk);
      exp_eob  = i_tuser[resizer_pkg::HDR_EOB_BIT] & i_tlast;
      exp_last = (resizer_pkg::size_t'(m_count + 16'd4) == m_size) || exp_eob;
      exp_user = i_tuser;   // Type, length and time unchanged
      exp_user[resizer_pkg::HDR_TSI_BIT] = i_tuser[resizer_pkg::HDR_TSI_BIT] & m_first;
      exp_user[resizer_pkg::HDR_EOB_BIT] = exp_eob;
      exp_user[resizer_pkg::HDR_SEQ_LSB +: 12] = m_seq;
      exp_user[resizer_pkg::HDR_SRC_LSB +: 16] = i_tuser[resizer_pkg::HDR_DST_LSB +: 16];
      exp_user[resizer_pkg::HDR_DST_LSB +: 16] = m_dest;
      xfer = i_tvalid && o_tready;
      check_value("i_tready", o_tready, i_tready);
      check_value("o_tvalid", i_tvalid, o_tvalid);
      check_value("o_tdata", i_tdata, o_tdata);
      if (i_tvalid) begin
         check_value("o_tlast", exp_last, o_tlast);
         check_value("o_tuser", exp_user, o_tuser);
      end
      if (xfer && exp_last) begin
         m_count = '0;
         m_first = exp_eob;   // Next packet opens a burst
         if (!exp_eob && m_seq == 12'hFFF) begin
            seq_wrapped = 1'b1;
         end
         m_seq = exp_eob ? 12'd0 : m_seq + 12'd1;
      end else if (xfer) begin
         m_count = m_count + 16'd4;
      end
      if (xfer && close_pending) begin
         close_pending = 1'b0;
         valid_pct     = 0;   // Go idle after the burst end
      end
      if (i_set_stb && i_set_addr == resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_DEST)) begin
         m_dest = i_set_data[15:0];
      end
      if (i_set_stb && i_set_addr == resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_PKT_SIZE)) begin
         m_size = i_set_data[15:0];
      end

      @(posedge clk);
      i_set_stb  <= pend_stb;
      i_set_addr <= pend_addr;
      i_set_data <= pend_data;
      pend_stb = 1'b0;
      o_tready <= chance(ready_pct);
      if (!(i_tvalid && !o_tready)) begin   // A stalled beat stays put
         hdr = random_header();
         hdr[resizer_pkg::HDR_TSI_BIT] = chance(tsi_pct);
         if (close_req) begin
            hdr[resizer_pkg::HDR_EOB_BIT] = 1'b1;
            i_tvalid <= 1'b1;
            i_tlast  <= 1'b1;
            close_req     = 1'b0;
            close_pending = 1'b1;
         end else begin
            hdr[resizer_pkg::HDR_EOB_BIT] = chance(eob_pct);
            i_tvalid <= chance(valid_pct);
            i_tlast  <= chance(last_pct);
         end
         i_tdata <= next_random();
         i_tuser <= hdr;
      end
   endtask

   task automatic write_reg(logic [resizer_pkg::SET_ADDR_W-1:0] addr,
                            logic [resizer_pkg::SET_DATA_W-1:0] data);
      pend_stb  = 1'b1;
      pend_addr = addr;
      pend_data = data;
      run_cycle();
   endtask

   // Ends the packet and burst with one forced beat, then leaves the stream idle
   task automatic close_burst();
      close_req = 1'b1;
      do begin
         run_cycle();
      end while (close_req || close_pending);
      run_cycle();
   endtask

   task automatic program_size(resizer_pkg::size_t size);
      set_traffic(0, 50, 0, 0);   // Stream idle while the size changes
      write_reg(resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_PKT_SIZE), 32'(size));
      run_cycle();
   endtask

   initial begin
      reset      = 1'b1;
      i_set_stb  = 1'b0;
      i_set_addr = '0;
      i_set_data = '0;
      i_tdata    = '0;
      i_tuser    = '0;
      i_tlast    = 1'b0;
      i_tvalid   = 1'b0;
      o_tready   = 1'b0;
      m_count = '0;
      m_size  = '0;
      m_dest  = '0;
      m_seq   = '0;
      m_first = 1'b1;
      seq_wrapped   = 1'b0;
      pend_stb      = 1'b0;
      pend_addr     = '0;
      pend_data     = '0;
      close_req     = 1'b0;
      close_pending = 1'b0;
      tsi_pct = 50;
      set_traffic(0, 50, 0, 0);
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      // Register writes, including addresses outside the map
      write_reg(resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_DEST), next_random());
      program_size(16'd16);
      write_reg(8'h47, next_random());
      set_traffic(80, 80, 0, 20);
      repeat (P_REG / 2) run_cycle();
      write_reg(8'hFF, next_random());
      write_reg(resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_DEST), next_random());
      write_reg(8'h02, next_random());
      repeat (P_REG / 2) run_cycle();
      close_burst();

      // Resizing over a spread of packet sizes
      for (int r = 0; r < N_RESIZE; r++) begin
         program_size(random_size());
         set_traffic(85, 85, 0, 30);
         repeat (P_RESIZE) run_cycle();
         close_burst();
      end

      // Burst ends landing mid-packet
      program_size(random_size());
      set_traffic(85, 85, 25, 30);
      repeat (P_BURST) run_cycle();
      close_burst();

      // One long burst of single-beat packets
      program_size(16'd4);
      set_traffic(100, 95, 0, 0);
      repeat (P_SEQ) run_cycle();
      if (!seq_wrapped) begin
         $display("The sequence counter never wrapped during the long burst");
         $display("*** FAILED ***");
         $fatal(1, "Sequence wrap not reached");
      end
      close_burst();

      // Heavy back-pressure with destination changes on the fly
      program_size(random_size());
      set_traffic(60, 50, 10, 20);
      repeat (P_STALL / 2) run_cycle();
      write_reg(resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_DEST), next_random());
      repeat (P_STALL / 2) run_cycle();
      close_burst();

      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- source/resizer_top.sv
// Top level of the packet resizer path, settings decode, resizer and sequence stamper
`timescale 1ns/1ps

module resizer_top (
   input  logic                                clk,
   input  logic                                reset,

   // Settings bus
   input  logic                                i_set_stb,
   input  logic [resizer_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [resizer_pkg::SET_DATA_W-1:0] i_set_data,

   // Input stream
   input  resizer_pkg::data_t                  i_tdata,
   input  resizer_pkg::header_t                i_tuser,
   input  logic                                i_tlast,
   input  logic                                i_tvalid,
   output logic                                i_tready,

   // Output stream
   output resizer_pkg::data_t                  o_tdata,
   output resizer_pkg::header_t                o_tuser,
   output logic                                o_tlast,
   output logic                                o_tvalid,
   input  logic                                o_tready
);

   resizer_pkg::sid_t  dest;       // Programmed destination
   resizer_pkg::size_t pkt_size;   // Programmed packet size

   stream_if in_s ();    // Ports into the resizer
   stream_if mid_s ();   // Resizer into the stamper

   // Input ports onto the first stream
   assign in_s.tdata  = i_tdata;
   assign in_s.tuser  = i_tuser;
   assign in_s.tlast  = i_tlast;
   assign in_s.tvalid = i_tvalid;
   assign i_tready    = in_s.tready;

   resizer_settings u_settings (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_dest     (dest),
      .o_pkt_size (pkt_size)
   );

   packet_resizer u_resizer (
      .clk        (clk),
      .reset      (reset),
      .i_dest     (dest),
      .i_pkt_size (pkt_size),
      .i_s        (in_s.sink),
      .o_s        (mid_s.source)
   );

   // Stamper drives the output ports directly
   seq_stamper u_stamper (
      .clk              (clk),
      .reset            (reset),
      .i_s              (mid_s.sink),
      .o_stamped_tdata  (o_tdata),
      .o_stamped_tuser  (o_tuser),
      .o_stamped_tlast  (o_tlast),
      .o_stamped_tvalid (o_tvalid),
      .i_stamped_tready (o_tready)
   );

endmodule

//--- source/seq_stamper.sv
// Sequence stamper that numbers the packets of each burst from zero
`timescale 1ns/1ps

module seq_stamper (
   input  logic                 clk,
   input  logic                 reset,
   stream_if.sink               i_s,
   output resizer_pkg::data_t   o_stamped_tdata,
   output resizer_pkg::header_t o_stamped_tuser,
   output logic                 o_stamped_tlast,
   output logic                 o_stamped_tvalid,
   input  logic                 i_stamped_tready
);

   resizer_pkg::seq_t    seq_cnt;    // Packet number within burst
   resizer_pkg::header_t hdr;
   logic                 beat_done;
   logic                 pkt_done;   // Last beat of a packet transfers
   logic                 eob;

   always_comb begin
      beat_done = i_s.tvalid && i_stamped_tready;
      pkt_done  = beat_done && i_s.tlast;
      eob       = i_s.tuser[resizer_pkg::HDR_EOB_BIT];
   end

   // Replace only the sequence field
   always_comb begin
      hdr = i_s.tuser;
      hdr[resizer_pkg::HDR_SEQ_LSB +: $bits(resizer_pkg::seq_t)] = seq_cnt;
   end

   assign o_stamped_tdata  = i_s.tdata;
   assign o_stamped_tuser  = hdr;
   assign o_stamped_tlast  = i_s.tlast;
   assign o_stamped_tvalid = i_s.tvalid;
   assign i_s.tready       = i_stamped_tready;

   always_ff @(posedge clk) begin
      if (reset) begin
         seq_cnt <= '0;
      end else if (pkt_done) begin
         if (eob) begin
            seq_cnt <= '0;            // New burst numbers from zero
         end else begin
            seq_cnt <= seq_cnt + 1'b1;  // Wraps at 12 bits
         end
      end
   end

   // Numbering moves only on a completed packet
   a_seq_hold : assert property (
      @(posedge clk) disable iff (reset)
      !pkt_done |=> $stable(seq_cnt)
   ) else $error("Sequence counter moved without a packet end");

endmodule

//--- source/packet_resizer.sv
// Resizing core that cuts the stream into fixed-size packets and rewrites the header
`timescale 1ns/1ps

module packet_resizer (
   input  logic               clk,
   input  logic               reset,
   input  resizer_pkg::sid_t  i_dest,
   input  resizer_pkg::size_t i_pkt_size,
   stream_if.sink             i_s,
   stream_if.source           o_s
);

   // Incoming header fields
   resizer_pkg::pkt_type_t type_in;
   logic                   tsi_in;
   logic                   eob_in;
   resizer_pkg::seq_t      seq_in;
   resizer_pkg::len_t      len_in;
   resizer_pkg::sid_t      dst_in;
   resizer_pkg::time_t     time_in;

   // Rewritten flags and packet state
   logic                   tsi_out;
   logic                   eob_out;
   logic                   last_out;
   logic                   beat_done;        // Beat transfers this cycle
   logic                   first_of_burst;   // Next packet opens a burst
   resizer_pkg::size_t     count;            // Bytes already sent in packet
   resizer_pkg::size_t     count_next;

   // Split the sideband into its fields
   always_comb begin
      type_in = i_s.tuser[resizer_pkg::HDR_TYPE_MSB -: $bits(resizer_pkg::pkt_type_t)];
      tsi_in  = i_s.tuser[resizer_pkg::HDR_TSI_BIT];
      eob_in  = i_s.tuser[resizer_pkg::HDR_EOB_BIT];
      seq_in  = i_s.tuser[resizer_pkg::HDR_SEQ_LSB +: $bits(resizer_pkg::seq_t)];
      len_in  = i_s.tuser[resizer_pkg::HDR_LEN_LSB +: $bits(resizer_pkg::len_t)];
      dst_in  = i_s.tuser[resizer_pkg::HDR_DST_LSB +: $bits(resizer_pkg::sid_t)];
      time_in = i_s.tuser[$bits(resizer_pkg::time_t)-1:0];
   end

   always_comb begin
      tsi_out    = tsi_in && first_of_burst;   // Only first packet of burst
      eob_out    = eob_in && i_s.tlast;        // Only on the closing beat
      count_next = count + resizer_pkg::size_t'(resizer_pkg::BYTES_PER_BEAT);
      last_out   = (count_next == i_pkt_size) || eob_out;
      beat_done  = i_s.tvalid && o_s.tready;
   end

   // Straight through with zero latency
   assign o_s.tdata  = i_s.tdata;
   assign o_s.tvalid = i_s.tvalid;
   assign o_s.tlast  = last_out;
   assign i_s.tready = o_s.tready;

   // Old destination becomes the source. The incoming source is dropped
   assign o_s.tuser = {type_in, tsi_out, eob_out, seq_in, len_in,
                       dst_in, i_dest, time_in};

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (beat_done) begin
         count <= last_out ? '0 : count_next;   // Restart on every packet end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         first_of_burst <= 1'b1;
      end else if (beat_done && last_out) begin
         first_of_burst <= eob_out;
      end
   end

   // A sane packet size is never overrun
   a_count_in_range : assert property (
      @(posedge clk) disable iff (reset)
      (i_s.tvalid && (i_pkt_size != '0) && (i_pkt_size[1:0] == 2'b00)) |->
         (count < i_pkt_size)
   ) else $error("Byte count %0d reached packet size %0d", count, i_pkt_size);

   // Stalled beats must be held by the producer
   a_stall_hold : assert property (
      @(posedge clk) disable iff (reset)
      (i_s.tvalid && !i_s.tready) |=>
         (i_s.tvalid && $stable(i_s.tdata) && $stable(i_s.tuser) && $stable(i_s.tlast))
   ) else $error("Input beat changed while stalled");

endmodule

//--- source/resizer_settings.sv
// Settings bus decoder holding the destination and packet-size registers
`timescale 1ns/1ps

module resizer_settings (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                i_set_stb,
   input  logic [resizer_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  logic [resizer_pkg::SET_DATA_W-1:0] i_set_data,
   output resizer_pkg::sid_t                   o_dest,
   output resizer_pkg::size_t                  o_pkt_size
);

   logic hit_dest;   // Write aimed at destination
   logic hit_size;   // Write aimed at packet size

   // Address decode
   always_comb begin
      hit_dest = i_set_stb &&
                 (i_set_addr == resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_DEST));
      hit_size = i_set_stb &&
                 (i_set_addr == resizer_pkg::SET_ADDR_W'(resizer_pkg::REG_PKT_SIZE));
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         o_dest <= '0;
      end else if (hit_dest) begin
         o_dest <= i_set_data[$bits(resizer_pkg::sid_t)-1:0];  // Low bits only
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         o_pkt_size <= '0;
      end else if (hit_size) begin
         o_pkt_size <= i_set_data[$bits(resizer_pkg::size_t)-1:0];
      end
   end

   // A single strobe may never land in both registers
   a_addr_distinct : assert property (
      @(posedge clk) disable iff (reset)
      i_set_stb |-> !(hit_dest && hit_size)
   ) else $error("Resizer register addresses overlap");

endmodule

//--- source/stream_if.sv
// Valid/ready stream with header sideband, used between the resizer stages
`timescale 1ns/1ps

interface stream_if;

   resizer_pkg::data_t   tdata;   // Payload beat
   resizer_pkg::header_t tuser;   // Sideband header
   logic                 tlast;   // Packet end
   logic                 tvalid;
   logic                 tready;

   // Beat producer
   modport source (
      output tdata,
      output tuser,
      output tlast,
      output tvalid,
      input  tready
   );

   // Beat consumer
   modport sink (
      input  tdata,
      input  tuser,
      input  tlast,
      input  tvalid,
      output tready
   );

endinterface

//--- source/resizer_pkg.sv
// Shared widths, header field types and register map for the stream packet resizer
package resizer_pkg;

   // Payload and sideband types
   typedef logic [31:0]  data_t;      // One stream beat
   typedef logic [127:0] header_t;    // Full sideband header
   typedef logic [1:0]   pkt_type_t;  // Packet type field
   typedef logic [11:0]  seq_t;       // Sequence number
   typedef logic [15:0]  len_t;       // Length field
   typedef logic [15:0]  sid_t;       // Stream address, source or destination
   typedef logic [63:0]  time_t;      // Timestamp
   typedef logic [15:0]  size_t;      // Byte count and packet size

   // Header layout, time sits at the bottom from bit 0
   localparam int HDR_TYPE_MSB = 127;
   localparam int HDR_TSI_BIT  = 125;  // Time-stamp flag
   localparam int HDR_EOB_BIT  = 124;  // End of burst
   localparam int HDR_SEQ_LSB  = 112;
   localparam int HDR_LEN_LSB  = 96;
   localparam int HDR_SRC_LSB  = 80;
   localparam int HDR_DST_LSB  = 64;

   // Stream geometry
   localparam int BYTES_PER_BEAT = 4;  // Byte advance per beat

   // Settings bus
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Register map
   localparam int REG_BASE     = 0;
   localparam int REG_DEST     = REG_BASE;      // Outgoing destination
   localparam int REG_PKT_SIZE = REG_BASE + 1;  // Packet size in bytes

endpackage
